//--- project.f
+incdir+include
design/cpu_pkg.sv
design/alu.sv
design/reg_file.sv
design/pc_counter.sv
design/instr_mem.sv
design/cpu_control.sv
design/cpu_top.sv
tb/tb_cpu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tb_cpu_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu_top;
    import cpu_pkg::*;

    typedef struct packed {
        alu_op_e        op;
        logic           rand_ops;   // Operands from the LFSR
        logic [11:0]    imm_a;
        logic [11:0]    imm_b;
        logic [3:0]     rd;
        wb_t            exp;
    } alu_row_t;

    localparam int NUM_ROWS     = 16;
    localparam int QUIET_CYCLES = 12;   // Longer than one instruction

    logic                   clk;
    logic                   arst_n;
    logic                   start;
    logic                   imem_we;
    logic [`CPU_PC_W-1:0]   imem_addr;
    instr_t                 imem_wdata;
    logic                   busy;
    wb_t                    wb;
    logic                   exception;
    logic                   halted;

    // Operand B low bits give the shift amount
    alu_row_t alu_table [NUM_ROWS] = '{
        '{ALU_LSR,    1'b0, 12'h800, 12'h004, 4'd3,  '0},
        '{ALU_LSL,    1'b0, 12'hFFF, 12'h004, 4'd4,  '0},
        '{ALU_ASR,    1'b0, 12'h800, 12'h003, 4'd5,  '0},
        '{ALU_PASS_A, 1'b0, 12'h000, 12'h123, 4'd6,  '0},
        '{ALU_UADD,   1'b0, 12'hFFF, 12'h001, 4'd7,  '0},
        '{ALU_USUB,   1'b0, 12'h00A, 12'h003, 4'd8,  '0},
        '{ALU_USUB,   1'b1, 12'h000, 12'h000, 4'd9,  '0},
        '{ALU_AND,    1'b0, 12'h0F0, 12'h3CC, 4'd10, '0},
        '{ALU_OR,     1'b1, 12'h000, 12'h000, 4'd11, '0},
        '{ALU_XOR,    1'b0, 12'h555, 12'h555, 4'd12, '0},
        '{ALU_NOR,    1'b0, 12'h000, 12'h000, 4'd13, '0},
        '{ALU_GT,     1'b0, 12'h005, 12'hFFE, 4'd14, '0},
        '{ALU_GT,     1'b1, 12'h000, 12'h000, 4'd15, '0},
        '{ALU_CMP,    1'b0, 12'h7F0, 12'h7F0, 4'd3,  '0},
        '{ALU_ADD,    1'b0, 12'h7FF, 12'h801, 4'd4,  '0},
        '{ALU_ADD,    1'b1, 12'h000, 12'h000, 4'd5,  '0}
    };

    instr_t                 prog [$];
    string                  evt_name [$];
    logic                   evt_exc [$];
    wb_t                    evt_wb [$];
    int                     evt_gap [$];   // Cycles since the previous event
    logic [`CPU_XLEN-1:0]   rf_model [`CPU_NREG] = '{default: '0};
    int                     pending_instr = 0;
    logic [31:0]            lfsr_q = 32'd88549;
    int                     cycle_cnt = 0;
    int                     cycle_limit = 0;

    cpu_top i_dut (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .i_start      (start),
        .i_imem_we    (imem_we),
        .i_imem_addr  (imem_addr),
        .i_imem_wdata (imem_wdata),
        .o_busy       (busy),
        .o_wb         (wb),
        .o_exception  (exception),
        .o_halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [11:0] random_imm12();
        logic [11:0] v;
        v = '0;
        for (int k = 0; k < 12; k++) begin
            v = {v[10:0], lfsr_q[31]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic logic [`CPU_XLEN-1:0] sext12(input logic [11:0] v);
        return {{(`CPU_XLEN-12){v[11]}}, v};
    endfunction

    function automatic wb_t predict_alu(input alu_op_e op, input logic [`CPU_XLEN-1:0] a,
                                        input logic [`CPU_XLEN-1:0] b);
        wb_t    w;
        int     sh;
        w       = '0;
        w.valid = 1'b1;
        sh      = int'(b[4:0]);
        case (op)
            ALU_LSR:    w.data = a >> sh;
            ALU_LSL: begin
                w.data = a << sh;
                if (sh != 0) begin
                    w.flags.carry = a[32 - sh];   // Last bit shifted out
                end
            end
            ALU_ASR: begin
                w.data        = $signed(a) >>> sh;
                w.flags.carry = a[31];
            end
            ALU_PASS_A: w.data = a;
            ALU_UADD: begin
                w.data        = a + b;
                w.flags.carry = (w.data < a);
            end
            ALU_USUB: begin
                w.data        = b - a;
                w.flags.carry = (a > b);   // Borrow
            end
            ALU_AND:    w.data = a & b;
            ALU_OR:     w.data = a | b;
            ALU_XOR:    w.data = a ^ b;
            ALU_NOR: begin
                w.data        = ~(a | b);
                w.flags.carry = 1'b1;
            end
            ALU_GT:     w.data = {31'd0, ($signed(a) > $signed(b))};
            ALU_CMP:    w.data = {31'd0, (a == b)};
            ALU_ADD: begin
                w.data       = a + b;
                w.flags.ovfl = (a[31] == b[31]) && (w.data[31] != a[31]);
                // Sign of the true sum
                w.flags.carry = w.flags.ovfl ? a[31] : w.data[31];
            end
            default:    w.data = '0;
        endcase
        w.flags.zero = (w.data == '0);
        return w;
    endfunction

    function automatic instr_t encode(input cpu_op_e op, input alu_op_e alu_op,
                                      input logic [3:0] rd, input logic [3:0] rs1,
                                      input logic [3:0] rs2, input logic [11:0] imm);
        instr_t ins;
        ins.op     = op;
        ins.alu_op = alu_op;
        ins.rd     = rd;
        ins.rs1    = rs1;
        ins.rs2    = rs2;
        ins.pad    = imm[11:8];
        ins.imm    = imm[7:0];
        return ins;
    endfunction

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped on first failure");
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected wb %h, actual wb %h", name, exp, act);
            $display("  expected rd=%0d data=%h flags=%b, actual valid=%b rd=%0d data=%h flags=%b",
                     exp.rd, exp.data, exp.flags, act.valid, act.rd, act.data, act.flags);
            stop_with_failure();
        end
    endtask

    task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected flags %b, actual flags %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic add_event(input string name, input logic is_exc, input wb_t w);
        evt_name.push_back(name);
        evt_exc.push_back(is_exc);
        evt_wb.push_back(w);
        evt_gap.push_back(3 * pending_instr);
        pending_instr = 0;
    endtask

    task automatic emit_ldi(input string name, input logic [3:0] rd, input logic [11:0] imm);
        wb_t w;
        prog.push_back(encode(OP_LDI, ALU_PASS_A, rd, 4'd0, 4'd0, imm));
        w    = predict_alu(ALU_PASS_A, sext12(imm), '0);
        w.rd = rd;
        pending_instr++;
        add_event(name, 1'b0, w);
        if (rd != 4'd0) begin
            rf_model[rd] = sext12(imm);
        end
    endtask

    task automatic emit_skipped(input logic [3:0] rd, input logic [11:0] imm);
        prog.push_back(encode(OP_LDI, ALU_PASS_A, rd, 4'd0, 4'd0, imm));
    endtask

    task automatic emit_op(input string name, input alu_op_e op, input logic [3:0] rd,
                           input logic [3:0] rs1, input logic [3:0] rs2, input wb_t w);
        prog.push_back(encode(OP_ALU, op, rd, rs1, rs2, 12'h000));
        pending_instr++;
        if (w.flags.ovfl) begin
            add_event(name, 1'b1, w);   // Signed ADD overflow
        end else begin
            add_event(name, 1'b0, w);
            if (rd != 4'd0) begin
                rf_model[rd] = w.data;
            end
        end
    endtask

    task automatic emit_beq(input logic [3:0] rs1, input logic [3:0] rs2,
                            input logic [7:0] off, output logic taken);
        prog.push_back(encode(OP_BEQ, ALU_CMP, 4'd0, rs1, rs2, {4'h0, off}));
        pending_instr++;
        taken = (rf_model[rs1] == rf_model[rs2]);
    endtask

    task automatic emit_after_beq(input logic taken, input string name, input logic [3:0] rd,
                                  input logic [11:0] imm);
        if (taken) begin
            emit_skipped(rd, imm);
        end else begin
            emit_ldi(name, rd, imm);
        end
    endtask

    task automatic build_program();
        logic       taken;
        wb_t        w;
        alu_op_e    op;
        string      nm;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (alu_table[i].rand_ops) begin
                alu_table[i].imm_a = random_imm12();
                alu_table[i].imm_b = random_imm12();
            end
            alu_table[i].exp = predict_alu(alu_table[i].op, sext12(alu_table[i].imm_a),
                                           sext12(alu_table[i].imm_b));
            alu_table[i].exp.rd = alu_table[i].rd;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            op = alu_table[i].op;
            nm = $sformatf("row%0d_%s", i, op.name());
            emit_ldi({nm, "_lda"}, 4'd1, alu_table[i].imm_a);
            emit_ldi({nm, "_ldb"}, 4'd2, alu_table[i].imm_b);
            emit_op(nm, op, alu_table[i].rd, 4'd1, 4'd2, alu_table[i].exp);
        end
        emit_ldi("beq_lda", 4'd5, 12'h02A);
        emit_ldi("beq_ldb", 4'd6, 12'h02A);
        emit_beq(4'd5, 4'd6, 8'd1, taken);
        emit_after_beq(taken, "beq_taken_next", 4'd7, 12'h111);
        emit_beq(4'd5, 4'd0, 8'd1, taken);
        emit_after_beq(taken, "beq_fallthrough", 4'd8, 12'h222);
        emit_ldi("r0_write", 4'd0, 12'h155);   // Dropped by the register file
        w    = predict_alu(ALU_UADD, rf_model[0], rf_model[8]);
        w.rd = 4'd9;
        emit_op("r0_read", ALU_UADD, 4'd9, 4'd0, 4'd8, w);
        emit_ldi("ovf_lda", 4'd1, 12'h001);
        emit_ldi("ovf_ldb", 4'd2, 12'h01F);
        w    = predict_alu(ALU_LSL, rf_model[1], rf_model[2]);
        w.rd = 4'd3;
        emit_op("ovf_shift", ALU_LSL, 4'd3, 4'd1, 4'd2, w);
        w    = predict_alu(ALU_ADD, rf_model[3], rf_model[3]);
        w.rd = 4'd4;
        emit_op("ovf_add", ALU_ADD, 4'd4, 4'd3, 4'd3, w);
        emit_skipped(4'd10, 12'h333);   // Must never commit
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            imem_we    = 1'b1;
            imem_addr  = i[`CPU_PC_W-1:0];
            imem_wdata = prog[i];
            @(negedge clk);
        end
        imem_we = 1'b0;
    endtask

    task automatic run_program(input string run_name);
        int     idx;
        int     since;
        int     quiet;
        logic   exc_seen;
        logic   exp_evt;
        logic   exp_exc;
        string  nm;
        idx      = 0;
        since    = 0;
        quiet    = 0;
        exc_seen = 1'b0;
        start    = 1'b1;
        while (!(exc_seen && (quiet >= QUIET_CYCLES))) begin
            @(negedge clk);
            start = 1'b0;
            since++;
            if (exc_seen) begin
                quiet++;
            end
            exp_evt = (idx < evt_gap.size()) && (since == evt_gap[idx]);
            exp_exc = exp_evt && evt_exc[idx];
            if (idx < evt_name.size()) begin
                nm = {run_name, "/", evt_name[idx]};
            end else begin
                nm = {run_name, "/after_halt"};
            end
            check_bit({nm, " o_busy"}, !exc_seen, busy);
            check_bit({nm, " o_halted"}, exc_seen, halted);
            check_bit({nm, " o_exception"}, exp_exc, exception);
            if (exp_evt && !exp_exc) begin
                check_wb(nm, evt_wb[idx], wb);
            end else begin
                check_bit({nm, " o_wb.valid"}, 1'b0, wb.valid);
            end
            if (exp_evt) begin
                idx++;
                since    = 0;
                exc_seen = exc_seen || exp_exc;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
            $display("Timeout: the core did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        arst_n     = 1'b0;
        start      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        build_program();
        if (prog.size() > `CPU_IMEM_DEPTH) begin
            $display("Test program does not fit in the instruction memory");
            stop_with_failure();
        end
        cycle_limit = 4 * 3 * (2 * prog.size()) + 200;   // Two runs
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("reset o_busy", 1'b0, busy);
        check_bit("reset o_wb.valid", 1'b0, wb.valid);
        check_bit("reset o_exception", 1'b0, exception);
        check_bit("reset o_halted", 1'b0, halted);
        check_flags("reset flags", '0, wb.flags);
        load_program();
        run_program("run1");
        run_program("rerun");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_start,
    input  logic                    i_imem_we,
    input  logic [`CPU_PC_W-1:0]    i_imem_addr,
    input  cpu_pkg::instr_t         i_imem_wdata,
    output logic                    o_busy,
    output cpu_pkg::wb_t            o_wb,
    output logic                    o_exception,
    output logic                    o_halted
);
    import cpu_pkg::*;

    instr_t                             instr;
    logic [`CPU_PC_W-1:0]               pc;
    logic [`CPU_RADDR_W-1:0]            raddr_a;
    logic [`CPU_RADDR_W-1:0]            raddr_b;
    logic [`CPU_XLEN-1:0]               rdata_a;
    logic [`CPU_XLEN-1:0]               rdata_b;
    logic                               rf_we;
    logic [`CPU_RADDR_W-1:0]            rf_waddr;
    logic [`CPU_XLEN-1:0]               rf_wdata;
    alu_op_e                            alu_op;
    logic [`CPU_XLEN-1:0]               alu_a;
    logic [`CPU_XLEN-1:0]               alu_b;
    logic [`CPU_XLEN-1:0]               alu_rslt;
    alu_flags_t                         alu_flags;
    logic                               pc_clear;
    logic                               pc_inc;
    logic                               pc_load;
    logic signed [`CPU_OFFSET_W-1:0]    pc_offset;

    cpu_control u_control (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_start     (i_start),
        .i_instr     (instr),
        .i_rdata_a   (rdata_a),
        .i_rdata_b   (rdata_b),
        .i_alu_rslt  (alu_rslt),
        .i_alu_flags (alu_flags),
        .i_imem_we   (i_imem_we),
        .o_raddr_a   (raddr_a),
        .o_raddr_b   (raddr_b),
        .o_alu_op    (alu_op),
        .o_alu_a     (alu_a),
        .o_alu_b     (alu_b),
        .o_rf_we     (rf_we),
        .o_rf_waddr  (rf_waddr),
        .o_rf_wdata  (rf_wdata),
        .o_pc_clear  (pc_clear),
        .o_pc_inc    (pc_inc),
        .o_pc_load   (pc_load),
        .o_pc_offset (pc_offset),
        .o_busy      (o_busy),
        .o_wb        (o_wb),
        .o_exception (o_exception),
        .o_halted    (o_halted)
    );

    pc_counter u_pc (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_clear  (pc_clear),
        .i_inc    (pc_inc),
        .i_load   (pc_load),
        .i_offset (pc_offset),
        .o_pc     (pc)
    );

    instr_mem u_imem (
        .i_clk   (i_clk),
        .i_we    (i_imem_we),
        .i_waddr (i_imem_addr),
        .i_wdata (i_imem_wdata),
        .i_raddr (pc),
        .o_rdata (instr)
    );

    reg_file u_rf (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_raddr_a (raddr_a),
        .i_raddr_b (raddr_b),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b),
        .i_we      (rf_we),
        .i_waddr   (rf_waddr),
        .i_wdata   (rf_wdata)
    );

    alu u_alu (
        .i_op_code (alu_op),
        .i_op_a    (alu_a),
        .i_op_b    (alu_b),
        .o_rslt    (alu_rslt),
        .o_flags   (alu_flags)
    );

endmodule

//--- design/cpu_control.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_control (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_start,
    input  cpu_pkg::instr_t                 i_instr,
    input  logic [`CPU_XLEN-1:0]            i_rdata_a,
    input  logic [`CPU_XLEN-1:0]            i_rdata_b,
    input  logic [`CPU_XLEN-1:0]            i_alu_rslt,
    input  cpu_pkg::alu_flags_t             i_alu_flags,
    input  logic                            i_imem_we,
    output logic [`CPU_RADDR_W-1:0]         o_raddr_a,
    output logic [`CPU_RADDR_W-1:0]         o_raddr_b,
    output cpu_pkg::alu_op_e                o_alu_op,
    output logic [`CPU_XLEN-1:0]            o_alu_a,
    output logic [`CPU_XLEN-1:0]            o_alu_b,
    output logic                            o_rf_we,
    output logic [`CPU_RADDR_W-1:0]         o_rf_waddr,
    output logic [`CPU_XLEN-1:0]            o_rf_wdata,
    output logic                            o_pc_clear,
    output logic                            o_pc_inc,
    output logic                            o_pc_load,
    output logic signed [`CPU_OFFSET_W-1:0] o_pc_offset,
    output logic                            o_busy,
    output cpu_pkg::wb_t                    o_wb,
    output logic                            o_exception,
    output logic                            o_halted
);
    import cpu_pkg::*;

    ctrl_state_e                    state_q;
    ctrl_state_e                    state_d;
    instr_t                         instr_q;
    logic [`CPU_XLEN-1:0]           rslt_q;
    alu_flags_t                     flags_q;
    logic                           op_writes;
    logic                           op_beq;
    logic signed [`CPU_LDI_IMM_W-1:0] ldi_imm;
    logic                           wb_valid;

    assign op_writes = (instr_q.op == OP_ALU) || (instr_q.op == OP_LDI);
    assign op_beq    = (instr_q.op == OP_BEQ);
    assign ldi_imm   = {instr_q.pad, instr_q.imm};

    assign o_raddr_a = instr_q.rs1;
    assign o_raddr_b = instr_q.rs2;

    // Operand steering
    always_comb begin
        o_alu_op = ALU_PASS_A;
        o_alu_a  = i_rdata_a;
        o_alu_b  = i_rdata_b;
        case (instr_q.op)
            OP_ALU: o_alu_op = instr_q.alu_op;
            OP_LDI: o_alu_a = {{(`CPU_XLEN-`CPU_LDI_IMM_W){ldi_imm[`CPU_LDI_IMM_W-1]}}, ldi_imm};
            OP_BEQ: o_alu_op = ALU_CMP;
            default: o_alu_op = ALU_PASS_A;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_HALT: begin
                if (i_start) begin
                    state_d = ST_FETCH;
                end
            end
            ST_FETCH: state_d = ST_EXEC;
            ST_EXEC:  state_d = (op_writes || op_beq) ? ST_WRITE : ST_HALT;   // Unknown ops halt
            ST_WRITE: state_d = o_exception ? ST_HALT : ST_FETCH;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ST_IDLE;
            flags_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_EXEC) begin
                flags_q <= i_alu_flags;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == ST_FETCH) begin
            instr_q <= i_instr;
        end
        if (state_q == ST_EXEC) begin
            rslt_q <= i_alu_rslt;
        end
    end

    assign o_exception = (state_q == ST_WRITE) && (instr_q.op == OP_ALU) && flags_q.ovfl;
    assign wb_valid    = (state_q == ST_WRITE) && op_writes && !o_exception;

    assign o_rf_we    = wb_valid;
    assign o_rf_waddr = instr_q.rd;
    assign o_rf_wdata = rslt_q;

    assign o_pc_clear  = i_start && ((state_q == ST_IDLE) || (state_q == ST_HALT));
    assign o_pc_load   = (state_q == ST_WRITE) && op_beq && rslt_q[0];   // Taken BEQ
    assign o_pc_inc    = (state_q == ST_WRITE) && !o_pc_load;
    assign o_pc_offset = instr_q.imm;

    assign o_busy   = (state_q == ST_FETCH) || (state_q == ST_EXEC) || (state_q == ST_WRITE);
    assign o_halted = (state_q == ST_HALT);

    assign o_wb.valid = wb_valid;
    assign o_wb.rd    = instr_q.rd;
    assign o_wb.data  = rslt_q;
    assign o_wb.flags = flags_q;
    assign o_wb.spare = '0;

    a_no_load_busy: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_busy |-> !i_imem_we
    );

    // Exception needs the ALU overflow seen in EXEC
    a_exc_from_ovfl: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_exception |-> $past(i_alu_flags.ovfl)
    );

    // Overflowing ADD never commits
    a_ovfl_no_wb: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (state_q == ST_EXEC) && (instr_q.op == OP_ALU) && i_alu_flags.ovfl |=> !o_wb.valid
    );

endmodule

//--- design/instr_mem.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module instr_mem (
    input  logic                    i_clk,
    input  logic                    i_we,
    input  logic [`CPU_PC_W-1:0]    i_waddr,
    input  cpu_pkg::instr_t         i_wdata,
    input  logic [`CPU_PC_W-1:0]    i_raddr,
    output cpu_pkg::instr_t         o_rdata
);
    import cpu_pkg::*;

    instr_t mem [`CPU_IMEM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr];   // Async read at the PC

endmodule

//--- design/pc_counter.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pc_counter (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_clear,
    input  logic                            i_inc,
    input  logic                            i_load,
    input  logic signed [`CPU_OFFSET_W-1:0] i_offset,
    output logic [`CPU_PC_W-1:0]            o_pc
);

    logic [`CPU_PC_W-1:0] pc_q;
    logic [`CPU_PC_W-1:0] offset_trunc;

    assign offset_trunc = i_offset[`CPU_PC_W-1:0];   // Wraps modulo depth

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= '0;
        end else if (i_clear) begin
            pc_q <= '0;
        end else if (i_load) begin
            pc_q <= pc_q + 1'b1 + offset_trunc;
        end else if (i_inc) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    assign o_pc = pc_q;

    a_inc_load_excl: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        !(i_inc && i_load)
    );

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic [`CPU_RADDR_W-1:0]     i_raddr_a,
    input  logic [`CPU_RADDR_W-1:0]     i_raddr_b,
    output logic [`CPU_XLEN-1:0]        o_rdata_a,
    output logic [`CPU_XLEN-1:0]        o_rdata_b,
    input  logic                        i_we,
    input  logic [`CPU_RADDR_W-1:0]     i_waddr,
    input  logic [`CPU_XLEN-1:0]        i_wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `CPU_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin   // r0 is read-only
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

    a_waddr_known: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        i_we |-> !$isunknown(i_waddr)
    );

endmodule

//--- design/alu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu (
    input  cpu_pkg::alu_op_e        i_op_code,
    input  logic [`CPU_XLEN-1:0]    i_op_a,
    input  logic [`CPU_XLEN-1:0]    i_op_b,
    output logic [`CPU_XLEN-1:0]    o_rslt,
    output cpu_pkg::alu_flags_t     o_flags
);
    import cpu_pkg::*;

    logic [`CPU_XLEN:0]         rslt_ext;   // Top bit is the carry
    logic                       ovfl;
    logic [`CPU_SHAMT_W-1:0]    shamt;

    assign shamt = i_op_b[`CPU_SHAMT_W-1:0];

    always_comb begin
        rslt_ext = '0;
        ovfl     = 1'b0;
        case (i_op_code)
            ALU_LSR: begin
                rslt_ext = {1'b0, i_op_a >> shamt};
            end
            ALU_LSL: begin
                rslt_ext = {1'b0, i_op_a} << shamt;   // Last bit out lands in carry
            end
            ALU_ASR: begin
                rslt_ext = $signed({i_op_a[`CPU_XLEN-1], i_op_a}) >>> shamt;
            end
            ALU_PASS_A: begin
                rslt_ext = {1'b0, i_op_a};
            end
            ALU_UADD: begin
                rslt_ext = {1'b0, i_op_a} + {1'b0, i_op_b};
            end
            ALU_USUB: begin
                rslt_ext = {1'b0, i_op_b} - {1'b0, i_op_a};   // Carry is the borrow
            end
            ALU_AND: begin
                rslt_ext = {1'b0, i_op_a & i_op_b};
            end
            ALU_OR: begin
                rslt_ext = {1'b0, i_op_a | i_op_b};
            end
            ALU_XOR: begin
                rslt_ext = {1'b0, i_op_a ^ i_op_b};
            end
            ALU_NOR: begin
                rslt_ext = ~({1'b0, i_op_a} | {1'b0, i_op_b});   // Carry always set
            end
            ALU_GT: begin
                rslt_ext = {{`CPU_XLEN{1'b0}}, $signed(i_op_a) > $signed(i_op_b)};
            end
            ALU_CMP: begin
                rslt_ext = {{`CPU_XLEN{1'b0}}, i_op_a == i_op_b};
            end
            ALU_ADD: begin
                rslt_ext = {i_op_a[`CPU_XLEN-1], i_op_a} + {i_op_b[`CPU_XLEN-1], i_op_b};
                // Operand signs agree but result sign differs
                ovfl = (i_op_a[`CPU_XLEN-1] == i_op_b[`CPU_XLEN-1]) &&
                       (rslt_ext[`CPU_XLEN-1] != i_op_a[`CPU_XLEN-1]);
            end
            default: begin
                rslt_ext = '0;   // Unused codes
            end
        endcase
    end

    assign o_rslt        = rslt_ext[`CPU_XLEN-1:0];
    assign o_flags.zero  = (o_rslt == '0);
    assign o_flags.carry = rslt_ext[`CPU_XLEN];
    assign o_flags.ovfl  = ovfl;

endmodule

//--- design/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    // Execute block opcodes
    typedef enum logic [3:0] {
        ALU_LSR    = 4'd0,
        ALU_LSL    = 4'd1,
        ALU_ASR    = 4'd2,
        ALU_PASS_A = 4'd3,
        ALU_UADD   = 4'd4,
        ALU_USUB   = 4'd5,   // rs2 minus rs1
        ALU_AND    = 4'd6,
        ALU_OR     = 4'd7,
        ALU_XOR    = 4'd8,
        ALU_NOR    = 4'd9,
        ALU_GT     = 4'd10,
        ALU_CMP    = 4'd11,
        ALU_ADD    = 4'd12
    } alu_op_e;

    typedef enum logic [3:0] {
        OP_ALU  = 4'd0,
        OP_LDI  = 4'd1,
        OP_BEQ  = 4'd2,
        OP_HALT = 4'd3
    } cpu_op_e;

    typedef struct packed {
        cpu_op_e                            op;
        alu_op_e                            alu_op;
        logic [`CPU_RADDR_W-1:0]            rd;
        logic [`CPU_RADDR_W-1:0]            rs1;
        logic [`CPU_RADDR_W-1:0]            rs2;
        logic [3:0]                         pad;     // Upper LDI immediate bits
        logic signed [`CPU_OFFSET_W-1:0]    imm;
    } instr_t;

    typedef struct packed {
        logic zero;
        logic carry;
        logic ovfl;
    } alu_flags_t;

    typedef struct packed {
        logic                       valid;
        logic [`CPU_RADDR_W-1:0]    rd;
        logic [`CPU_XLEN-1:0]       data;
        alu_flags_t                 flags;
        logic [1:0]                 spare;   // Always zero
    } wb_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_WRITE,
        ST_HALT
    } ctrl_state_e;

endpackage

//--- include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath width
`define CPU_XLEN 32

// Register file size and address width
`define CPU_NREG 16
`define CPU_RADDR_W 4

// Instruction memory size and PC width
`define CPU_IMEM_DEPTH 64
`define CPU_PC_W 6

// Branch offset width from the instruction imm field
`define CPU_OFFSET_W 8

// LDI immediate is pad:imm
`define CPU_LDI_IMM_W 12

// ALU shift amount comes from the low bits of operand B
`define CPU_SHAMT_W 5

`endif
